// File: hw/glb_cfg_pkg.sv
// ----------------------------------------------------------------------
// global buffer configuration package
// sizes, address fields, opcode and the request and response structs
// shared by the tile chain, the controllers and the banks.
// ----------------------------------------------------------------------
package glb_cfg_pkg;

    // chain geometry.
    localparam int num_tiles      = 4;
    localparam int banks_per_tile = 2;
    localparam int bank_depth     = 64;    // words per bank.

    // address fields, low to high: word, bank, tile.
    localparam int bank_addr_width = 6;
    localparam int bank_sel_width  = 1;
    localparam int tile_sel_width  = 2;
    localparam int cfg_addr_width  = bank_addr_width + bank_sel_width + tile_sel_width;

    localparam int cfg_data_width = 32;

    // bit position where each address field starts.
    localparam int bank_sel_lsb = bank_addr_width;
    localparam int tile_sel_lsb = bank_addr_width + bank_sel_width;

    // request opcode.
    typedef enum logic [1:0] {
        cfg_nop   = 2'b00,
        cfg_write = 2'b01,
        cfg_read  = 2'b10
    } cfg_op_t;

    // request travelling east, 43 bits.
    typedef struct packed {
        cfg_op_t                   op;
        logic [cfg_addr_width-1:0] addr;
        logic [cfg_data_width-1:0] wr_data;
    } cfg_req_t;

    // response travelling west, 33 bits.
    typedef struct packed {
        logic [cfg_data_width-1:0] rd_data;
        logic                      rd_data_valid;
    } cfg_rsp_t;

    // controller to bank, 40 bits.
    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [bank_addr_width-1:0] addr;
        logic [cfg_data_width-1:0]  wr_data;
    } bank_req_t;

endpackage

// File: hw/glb_cfg_bank.sv
// ----------------------------------------------------------------------
// global buffer sram bank
// single port word memory with a registered read port and a
// one cycle read-valid flag.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module glb_cfg_bank
    import glb_cfg_pkg::*;
(
    input  logic      clk,
    input  bank_req_t bank_req,
    output cfg_rsp_t  bank_rsp,
    input  logic      reset
);

    logic [cfg_data_width-1:0] mem [bank_depth];
    logic [cfg_data_width-1:0] rd_data;
    logic                      rd_data_valid;

    // synchronous write.
    always_ff @(posedge clk) begin
        if (bank_req.wr_en) begin
            mem[bank_req.addr] <= bank_req.wr_data;
        end
    end

    // read data holds until the next read.
    always_ff @(posedge clk) begin
        if (bank_req.rd_en) begin
            rd_data <= mem[bank_req.addr];
        end
    end

    // valid is a single cycle pulse per read.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= bank_req.rd_en;
        end
    end

    assign bank_rsp.rd_data       = rd_data;
    assign bank_rsp.rd_data_valid = rd_data_valid;

endmodule

// File: hw/glb_tile_cfg_ctrl.sv
// ----------------------------------------------------------------------
// global buffer tile configuration controller
// decodes requests for the local banks, forwards every request east
// and merges local read data into the response returning west.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module glb_tile_cfg_ctrl
    import glb_cfg_pkg::*;
#(
    parameter int tile_id = 0
) (
    input  logic                             clk,
    input  logic                             reset,

    // request path, west in and east out.
    input  cfg_req_t                         req_west,
    output cfg_req_t                         req_east,

    // response path, east in and west out.
    input  cfg_rsp_t                         rsp_east,
    output cfg_rsp_t                         rsp_west,

    // local banks.
    output bank_req_t [banks_per_tile-1:0]   bank_req,
    input  cfg_rsp_t  [banks_per_tile-1:0]   bank_rsp
);

    logic [tile_sel_width-1:0] req_tile;
    logic [bank_sel_width-1:0] req_bank;
    logic                      tile_hit;
    logic [banks_per_tile-1:0] bank_hit;
    logic [banks_per_tile-1:0] bank_rd_en;
    logic [banks_per_tile-1:0] bank_rd_en_d1;    // bank read last cycle.

    cfg_op_t                   req_op_q;
    logic [cfg_addr_width-1:0] req_addr_q;
    logic [cfg_data_width-1:0] req_data_q;

    cfg_rsp_t                  rsp_next;
    logic                      rsp_valid_q;
    logic [cfg_data_width-1:0] rsp_data_q;

    assign req_tile = req_west.addr[tile_sel_lsb +: tile_sel_width];
    assign req_bank = req_west.addr[bank_sel_lsb +: bank_sel_width];
    assign tile_hit = (req_tile == tile_sel_width'(tile_id));

    // per bank decode, at most one bank of one tile is hit.
    always_comb begin
        for (int i = 0; i < banks_per_tile; i++) begin
            bank_hit[i]        = tile_hit && (req_bank == bank_sel_width'(i));
            bank_rd_en[i]      = bank_hit[i] && (req_west.op == cfg_read);
            bank_req[i].wr_en  = bank_hit[i] && (req_west.op == cfg_write);
            bank_req[i].rd_en  = bank_rd_en[i];
            bank_req[i].addr   = req_west.addr[bank_addr_width-1:0];
            bank_req[i].wr_data = req_west.wr_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_rd_en_d1 <= '0;
        end else begin
            bank_rd_en_d1 <= bank_rd_en;
        end
    end

    // eastward request register; only the opcode needs clearing.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_op_q <= cfg_nop;
        end else begin
            req_op_q <= req_west.op;
        end
    end

    always_ff @(posedge clk) begin
        req_addr_q <= req_west.addr;
        req_data_q <= req_west.wr_data;
    end

    assign req_east.op      = req_op_q;
    assign req_east.addr    = req_addr_q;
    assign req_east.wr_data = req_data_q;

    // local bank data wins over the stream from the east.
    always_comb begin
        rsp_next = rsp_east;
        for (int i = 0; i < banks_per_tile; i++) begin
            if (bank_rd_en_d1[i]) begin
                rsp_next = bank_rsp[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rsp_next.rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_next.rd_data_valid) begin
            rsp_data_q <= rsp_next.rd_data;    // hold last word otherwise.
        end
    end

    assign rsp_west.rd_data       = rsp_data_q;
    assign rsp_west.rd_data_valid = rsp_valid_q;

endmodule

// File: hw/glb_tile.sv
// ----------------------------------------------------------------------
// global buffer tile
// one configuration controller and its sram banks.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module glb_tile
    import glb_cfg_pkg::*;
#(
    parameter int tile_id = 0
) (
    input  logic     clk,
    input  logic     reset,
    input  cfg_req_t req_west,
    output cfg_req_t req_east,
    input  cfg_rsp_t rsp_east,
    output cfg_rsp_t rsp_west
);

    bank_req_t [banks_per_tile-1:0] bank_req;
    cfg_rsp_t  [banks_per_tile-1:0] bank_rsp;

    glb_tile_cfg_ctrl #(
        .tile_id (tile_id)
    ) i_cfg_ctrl (
        .clk      (clk),
        .reset    (reset),
        .req_west (req_west),
        .req_east (req_east),
        .rsp_east (rsp_east),
        .rsp_west (rsp_west),
        .bank_req (bank_req),
        .bank_rsp (bank_rsp)
    );

    // one bank per select value.
    for (genvar i = 0; i < banks_per_tile; i++) begin : g_bank
        glb_cfg_bank i_bank (
            .clk      (clk),
            .bank_req (bank_req[i]),
            .bank_rsp (bank_rsp[i]),
            .reset    (reset)
        );
    end

endmodule

// File: hw/glb_cfg_chain.sv
// ----------------------------------------------------------------------
// global buffer configuration chain
// row of tiles chained west to east behind a single host port.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module glb_cfg_chain
    import glb_cfg_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  cfg_req_t host_req,
    output cfg_rsp_t host_rsp
);

    // element k feeds tile k from the west side.
    cfg_req_t [num_tiles:0] req_chain;
    cfg_rsp_t [num_tiles:0] rsp_chain;

    assign req_chain[0]         = host_req;
    assign rsp_chain[num_tiles] = '0;    // chain end, no responses.
    assign host_rsp             = rsp_chain[0];

    for (genvar t = 0; t < num_tiles; t++) begin : g_tile
        glb_tile #(
            .tile_id (t)
        ) i_tile (
            .clk      (clk),
            .reset    (reset),
            .req_west (req_chain[t]),
            .req_east (req_chain[t+1]),
            .rsp_east (rsp_chain[t+1]),
            .rsp_west (rsp_chain[t])
        );
    end

endmodule

// File: dv/tb_clk_gen.sv
// ----------------------------------------------------------------------
// testbench clock and reset generator
// 40 ns clock, reset held for the first 3 rising edges.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // half of the 40 ns period.
    end

    initial begin
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;             // released after the third edge.
    end

endmodule

// File: dv/glb_cfg_assertions.sv
// ----------------------------------------------------------------------
// tile controller assertions
// bank enable exclusivity, response reset state and bank read timing.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module glb_cfg_assertions
    import glb_cfg_pkg::*;
(
    input logic                           clk,
    input logic                           reset,
    input bank_req_t [banks_per_tile-1:0] bank_req,
    input cfg_rsp_t  [banks_per_tile-1:0] bank_rsp,
    input cfg_rsp_t                       rsp_west
);

    // all write and read enables of the tile, two per bank.
    logic [2*banks_per_tile-1:0] bank_en;

    for (genvar i = 0; i < banks_per_tile; i++) begin : g_en
        assign bank_en[2*i]   = bank_req[i].wr_en;
        assign bank_en[2*i+1] = bank_req[i].rd_en;
    end

    one_bank_enable: assert property (
        @(posedge clk) disable iff (reset) $onehot0(bank_en)
    ) else $error("more than one bank enable active in one cycle");

    // first cycle out of reset carries no response.
    rsp_idle_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !rsp_west.rd_data_valid
    ) else $error("rsp_west valid high right after reset release");

    for (genvar i = 0; i < banks_per_tile; i++) begin : g_bank_chk
        rd_en_gives_valid: assert property (
            @(posedge clk) disable iff (reset)
            bank_req[i].rd_en |=> bank_rsp[i].rd_data_valid
        ) else $error("bank read enable not followed by read valid");

        valid_needs_rd_en: assert property (
            @(posedge clk) disable iff (reset)
            bank_rsp[i].rd_data_valid |-> $past(bank_req[i].rd_en)
        ) else $error("bank read valid without a read one cycle earlier");
    end

endmodule

bind glb_tile_cfg_ctrl glb_cfg_assertions i_cfg_assertions (
    .clk      (clk),
    .reset    (reset),
    .bank_req (bank_req),
    .bank_rsp (bank_rsp),
    .rsp_west (rsp_west)
);

// File: dv/tb_glb_cfg_chain.sv
// ----------------------------------------------------------------------
// configuration chain testbench
// directed write and read tests against a reference memory model,
// with latency checks taken from the per-tile response timing.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_glb_cfg_chain
    import glb_cfg_pkg::*;
();

    logic     clk;
    logic     reset;
    cfg_req_t host_req;
    cfg_rsp_t host_rsp;

    // reference memory, indexed by the full configuration address.
    logic [cfg_data_width-1:0] ref_mem [num_tiles*banks_per_tile*bank_depth];
    logic [31:0]               lcg_state = 32'd96;

    int error_count   = 0;
    int timeout_count = 0;
    int check_count   = 0;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    glb_cfg_chain i_dut (
        .clk      (clk),
        .reset    (reset),
        .host_req (host_req),
        .host_rsp (host_rsp)
    );

    function automatic logic [cfg_data_width-1:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // word, then bank, then tile from low to high bits.
    function automatic logic [cfg_addr_width-1:0] addr_of(int tile, int bank, int word);
        return {tile[tile_sel_width-1:0], bank[bank_sel_width-1:0],
                word[bank_addr_width-1:0]};
    endfunction

    function automatic cfg_req_t make_req(cfg_op_t op, logic [cfg_addr_width-1:0] addr,
                                          logic [cfg_data_width-1:0] data);
        cfg_req_t req;
        req.op      = op;
        req.addr    = addr;
        req.wr_data = data;
        return req;
    endfunction

    function automatic int pair_word(int tile, int bank);
        return (tile * banks_per_tile + bank) * 7 + 3;
    endfunction

    // one cycle: drive at the rising edge, sample at the falling edge.
    task automatic step(input cfg_req_t req, output cfg_rsp_t rsp);
        @(posedge clk);
        host_req <= req;
        @(negedge clk);
        rsp = host_rsp;
    endtask

    // reset is only seen as released once it reads a clean low.
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (reset !== 1'b0 && cycles < 20);
        if (reset !== 1'b0) begin
            $display("Timeout: reset was not released within 20 cycles");
            timeout_count++;
        end
    endtask

    task automatic write_word(input logic [cfg_addr_width-1:0] addr);
        cfg_rsp_t                  rsp;
        logic [cfg_data_width-1:0] data;
        data = lcg_next();
        step(make_req(cfg_write, addr, data), rsp);
        ref_mem[addr] = data;
    endtask

    task automatic read_check(input logic [cfg_addr_width-1:0] addr);
        cfg_rsp_t rsp;
        int       wait_cycles;
        step(make_req(cfg_read, addr, '0), rsp);
        wait_cycles = 0;
        do begin
            step(make_req(cfg_nop, '0, '0), rsp);
            wait_cycles++;
        end while (!rsp.rd_data_valid && wait_cycles < 20);
        check_count++;
        if (!rsp.rd_data_valid) begin
            $display("Timeout: no read response for address 0x%03h within 20 cycles", addr);
            timeout_count++;
        end else if (rsp.rd_data !== ref_mem[addr]) begin
            $display("** Error @ %0t: read 0x%03h returned 0x%08h, expected 0x%08h",
                     $time, addr, rsp.rd_data, ref_mem[addr]);
            error_count++;
        end
    endtask

    task automatic test_reset_state();
        cfg_rsp_t rsp;
        for (int c = 0; c < 5; c++) begin
            step(make_req(cfg_nop, '0, '0), rsp);
            check_count++;
            if (rsp.rd_data_valid !== 1'b0) begin
                $display("** Error @ %0t: host_rsp valid high %0d cycles after reset",
                         $time, c);
                error_count++;
            end
        end
    endtask

    task automatic test_write_read_all();
        for (int t = 0; t < num_tiles; t++) begin
            for (int b = 0; b < banks_per_tile; b++) begin
                write_word(addr_of(t, b, pair_word(t, b)));
            end
        end
        for (int t = 0; t < num_tiles; t++) begin
            for (int b = 0; b < banks_per_tile; b++) begin
                read_check(addr_of(t, b, pair_word(t, b)));
            end
        end
    endtask

    // expects one valid cycle, exactly 2t+2 cycles after issue.
    task automatic test_read_latency();
        cfg_rsp_t                  rsp;
        logic [cfg_addr_width-1:0] addr;
        int                        valid_count;
        for (int t = 0; t < num_tiles; t++) begin
            addr        = addr_of(t, 0, pair_word(t, 0));
            valid_count = 0;
            step(make_req(cfg_read, addr, '0), rsp);
            for (int c = 1; c <= 20; c++) begin
                step(make_req(cfg_nop, '0, '0), rsp);
                if (rsp.rd_data_valid) begin
                    valid_count++;
                    check_count++;
                    if (c != 2 * t + 2) begin
                        $display("** Error @ %0t: tile %0d valid after %0d cycles, expected %0d",
                                 $time, t, c, 2 * t + 2);
                        error_count++;
                    end else if (rsp.rd_data !== ref_mem[addr]) begin
                        $display("** Error @ %0t: tile %0d read data 0x%08h, expected 0x%08h",
                                 $time, t, rsp.rd_data, ref_mem[addr]);
                        error_count++;
                    end
                end
            end
            if (valid_count == 0) begin
                $display("Timeout: tile %0d read gave no response within 20 cycles", t);
                timeout_count++;
            end
        end
    endtask

    task automatic test_address_isolation();
        for (int t = 0; t < num_tiles; t++) begin
            for (int b = 0; b < banks_per_tile; b++) begin
                write_word(addr_of(t, b, 5));
            end
        end
        write_word(addr_of(2, 1, 5));    // only this entry changes.
        for (int t = 0; t < num_tiles; t++) begin
            for (int b = 0; b < banks_per_tile; b++) begin
                if (!(t == 2 && b == 1)) begin
                    read_check(addr_of(t, b, 5));
                end
            end
        end
    endtask

    // farther tiles go last so that no two arrivals share a cycle.
    task automatic test_pipelined_reads();
        cfg_rsp_t                  rsp;
        cfg_req_t                  req;
        logic [cfg_addr_width-1:0] rd_addr [4];
        int                        arrival [4];
        int                        hit;
        for (int i = 0; i < 4; i++) begin
            rd_addr[i] = addr_of(2 + i / 2, i % 2, 20 + i);
            arrival[i] = i + 2 * (2 + i / 2) + 2;
            write_word(rd_addr[i]);
        end
        for (int c = 0; c < 20; c++) begin
            req = (c < 4) ? make_req(cfg_read, rd_addr[c], '0) : make_req(cfg_nop, '0, '0);
            step(req, rsp);
            hit = -1;
            for (int i = 0; i < 4; i++) begin
                if (arrival[i] == c) begin
                    hit = i;
                end
            end
            check_count++;
            if (hit < 0 && rsp.rd_data_valid) begin
                $display("** Error @ %0t: unexpected response in pipelined cycle %0d", $time, c);
                error_count++;
            end else if (hit >= 0 && !rsp.rd_data_valid) begin
                $display("** Error @ %0t: pipelined read %0d missing in cycle %0d",
                         $time, hit, c);
                error_count++;
            end else if (hit >= 0 && rsp.rd_data !== ref_mem[rd_addr[hit]]) begin
                $display("** Error @ %0t: pipelined read %0d data 0x%08h, expected 0x%08h",
                         $time, hit, rsp.rd_data, ref_mem[rd_addr[hit]]);
                error_count++;
            end
        end
    endtask

    task automatic test_write_then_read();
        logic [cfg_addr_width-1:0] addr;
        for (int t = 0; t < num_tiles; t++) begin
            addr = addr_of(t, t % 2, 40 + t);
            write_word(addr);
            write_word(addr);    // new word, read in the very next cycle.
            read_check(addr);
        end
    endtask

    initial begin
        host_req <= make_req(cfg_nop, '0, '0);
        wait_reset_release();
        test_reset_state();
        test_write_read_all();
        test_read_latency();
        test_address_isolation();
        test_pipelined_reads();
        test_write_then_read();
        $display("checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: glb_cfg_chain.f
hw/glb_cfg_pkg.sv
hw/glb_cfg_bank.sv
hw/glb_tile_cfg_ctrl.sv
hw/glb_tile.sv
hw/glb_cfg_chain.sv
dv/tb_clk_gen.sv
dv/glb_cfg_assertions.sv
dv/tb_glb_cfg_chain.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the configuration chain testbench with Verilator and runs it.
# The exit status is non-zero unless the testbench reports a pass.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_glb_cfg_chain \
    -f glb_cfg_chain.f \
    -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qF "Simulation finished: PASS" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed or did not build" >&2; exit 1; }
